/* bench/display_tb.sv */
`timescale 1ns/1ps

module display_tb
    import display_pkg::*;
();

    localparam int CLOCK_PERIOD = 20;
    localparam int FRAME_PIXELS = 640 * 400;

    // six frames of raster plus room for the register traffic.
    localparam longint WATCHDOG_CYCLES = 6 * FRAME_PIXELS + 50000;

    localparam axil_address_t CURSOR_REGISTER = 4'h0;
    localparam axil_address_t PIXEL_REGISTER = 4'h4;
    localparam axil_address_t CONTROL_REGISTER = 4'h8;
    localparam axil_address_t UNMAPPED_REGISTER = 4'hC;

    localparam axil_response_t OKAY = 2'b00;
    localparam axil_response_t SLVERR = 2'b10;

    logic clock_in;
    logic reset_n_in;
    axil_address_t axil_awaddr;
    logic axil_awvalid;
    logic axil_awready;
    axil_data_t axil_wdata;
    logic axil_wvalid;
    logic axil_wready;
    axil_response_t axil_bresp;
    logic axil_bvalid;
    logic axil_bready;
    axil_address_t axil_araddr;
    logic axil_arvalid;
    logic axil_arready;
    axil_data_t axil_rdata;
    axil_response_t axil_rresp;
    logic axil_rvalid;
    logic axil_rready;
    pixel_colour_t display_pixel;
    logic display_pixel_valid;
    logic display_frame_start;

    // last complete frame seen on the display output.
    pixel_colour_t captured_pixels [FRAME_PIXELS];
    int capture_index;
    event frame_started;
    event frame_captured;

    // reference model, keyed by buffer index times frame size plus address.
    pixel_colour_t model_pixels [int];
    int model_cursor;
    bit model_displayed;
    bit model_pending;

    integer seed;
    int mismatch_count;
    int failure_count;

    display_top dut0 (.*);

    initial begin
        clock_in = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock_in = ~clock_in;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("ERROR at %0t: watchdog expired before the tests finished", $time);
        $display("mismatches: %0d, other failures: %0d", mismatch_count, failure_count + 1);
        $display("=== FAIL ===");
        $finish;
    end

    // display outputs are registered, so the pre-edge value is the pixel.
    initial begin
        capture_index = FRAME_PIXELS;
        forever begin
            @(posedge clock_in);
            if (display_pixel_valid === 1'b1) begin
                if (display_frame_start === 1'b1) begin
                    capture_index = 0;
                    ->frame_started;
                end
                if (capture_index < FRAME_PIXELS) begin
                    captured_pixels[capture_index] = display_pixel;
                end
                if (capture_index == FRAME_PIXELS - 1) begin
                    ->frame_captured;
                end
                capture_index++;
            end
        end
    end

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------

    task automatic check_colour(input string name, input pixel_colour_t actual,
                                input pixel_colour_t expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_data(input string name, input axil_data_t actual,
                              input axil_data_t expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_response(input string name, input axil_response_t actual,
                                  input axil_response_t expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic report_failure(input string what);
        failure_count++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    // ------------------------------------------------------------
    // AXI4-Lite master
    // ------------------------------------------------------------

    task automatic send_write_request(input axil_address_t address, input axil_data_t data);
        bit accepted;
        accepted = 1'b0;
        axil_awaddr = address;
        axil_wdata = data;
        axil_awvalid = 1'b1;
        axil_wvalid = 1'b1;
        while (!accepted) begin
            @(posedge clock_in);
            accepted = axil_awready && axil_wready;
        end
        @(negedge clock_in);
        axil_awvalid = 1'b0;
        axil_wvalid = 1'b0;
    endtask

    task automatic collect_write_response(output axil_response_t response);
        bit done;
        done = 1'b0;
        axil_bready = 1'b1;
        while (!done) begin
            @(posedge clock_in);
            done = axil_bvalid;
        end
        response = axil_bresp;
        @(negedge clock_in);
        axil_bready = 1'b0;
    endtask

    task automatic axil_write(input axil_address_t address, input axil_data_t data,
                              output axil_response_t response);
        send_write_request(address, data);
        collect_write_response(response);
    endtask

    task automatic axil_read(input axil_address_t address, output axil_data_t data,
                             output axil_response_t response);
        bit done;
        done = 1'b0;
        axil_araddr = address;
        axil_arvalid = 1'b1;
        while (!done) begin
            @(posedge clock_in);
            done = axil_arready;
        end
        @(negedge clock_in);
        axil_arvalid = 1'b0;
        axil_rready = 1'b1;
        done = 1'b0;
        while (!done) begin
            @(posedge clock_in);
            done = axil_rvalid;
        end
        data = axil_rdata;
        response = axil_rresp;
        @(negedge clock_in);
        axil_rready = 1'b0;
    endtask

    // ------------------------------------------------------------
    // model helpers
    // ------------------------------------------------------------

    function automatic int pixel_key(input bit buffer, input int address);
        return int'(buffer) * FRAME_PIXELS + address;
    endfunction

    task automatic set_cursor(input int value);
        axil_response_t response;
        axil_write(CURSOR_REGISTER, axil_data_t'(value), response);
        check_response("bresp", response, OKAY);
        model_cursor = (value >= FRAME_PIXELS) ? 0 : value;
    endtask

    task automatic verify_cursor();
        axil_data_t data;
        axil_response_t response;
        axil_read(CURSOR_REGISTER, data, response);
        check_response("rresp", response, OKAY);
        check_data("cursor", data, axil_data_t'(model_cursor));
    endtask

    task automatic verify_status();
        axil_data_t data;
        axil_response_t response;
        axil_read(CONTROL_REGISTER, data, response);
        check_response("rresp", response, OKAY);
        check_data("status", data, axil_data_t'({model_displayed, ~model_pending}));
    endtask

    // the hidden buffer takes the pixel unless a swap is still waiting.
    task automatic write_pixel(input pixel_colour_t colour);
        axil_response_t response;
        axil_write(PIXEL_REGISTER, axil_data_t'(colour), response);
        check_response("bresp", response, model_pending ? SLVERR : OKAY);
        if (!model_pending) begin
            model_pixels[pixel_key(~model_displayed, model_cursor)] = colour;
            model_cursor = (model_cursor + 1) % FRAME_PIXELS;
        end
    endtask

    task automatic write_random_pixels(input int count);
        pixel_colour_t colour;
        repeat (count) begin
            colour = pixel_colour_t'($random(seed));
            write_pixel(colour);
        end
    endtask

    task automatic request_switch();
        axil_response_t response;
        axil_write(CONTROL_REGISTER, axil_data_t'(1), response);
        check_response("bresp", response, OKAY);
        model_pending = 1'b1;
    endtask

    task automatic wait_frames(input int count);
        repeat (count) @(frame_started);
        @(negedge clock_in);
    endtask

    // waits for the frame in progress to end and checks every written address.
    task automatic compare_frame(input bit buffer);
        @(frame_captured);
        foreach (model_pixels[key]) begin
            if (key / FRAME_PIXELS == int'(buffer)) begin
                check_colour($sformatf("display_pixel[%0d]", key % FRAME_PIXELS),
                             captured_pixels[key % FRAME_PIXELS], model_pixels[key]);
            end
        end
        @(negedge clock_in);
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------

    task automatic register_access();
        axil_data_t data;
        axil_response_t response;
        verify_status();
        set_cursor(1000);
        verify_cursor();
        set_cursor(300000);
        verify_cursor();
        axil_write(UNMAPPED_REGISTER, 32'h0000_1234, response);
        check_response("bresp", response, SLVERR);
        axil_read(UNMAPPED_REGISTER, data, response);
        check_response("rresp", response, SLVERR);
        check_data("rdata", data, '0);
    endtask

    task automatic pixel_auto_increment();
        int starts [3] = '{0, 1000, 255990};
        axil_data_t data;
        axil_response_t response;
        foreach (starts[i]) begin
            set_cursor(starts[i]);
            write_random_pixels(32);
            axil_read(CURSOR_REGISTER, data, response);
            check_data("cursor", data, axil_data_t'((starts[i] + 32) % FRAME_PIXELS));
        end
    endtask

    task automatic buffer_switch();
        request_switch();
        wait_frames(1);
        model_displayed = 1'b1;
        model_pending = 1'b0;
        compare_frame(1'b1);
        verify_status();
    endtask

    // the new values overlap addresses that the shown buffer already holds.
    task automatic tear_free_swap();
        pixel_colour_t colour;
        set_cursor(1000);
        write_random_pixels(32);
        wait_frames(1);
        compare_frame(1'b1);
        // this pixel is refused, so address 1000 keeps its earlier value.
        set_cursor(1000);
        request_switch();
        colour = ~model_pixels[pixel_key(1'b0, 1000)];
        write_pixel(colour);
        verify_status();
        verify_cursor();
        wait_frames(1);
        model_displayed = 1'b0;
        model_pending = 1'b0;
        verify_status();
        compare_frame(1'b0);
    endtask

    task automatic response_back_pressure();
        axil_data_t data;
        axil_response_t response;
        send_write_request(CURSOR_REGISTER, axil_data_t'(777));
        model_cursor = 777;
        axil_araddr = CURSOR_REGISTER;
        axil_arvalid = 1'b1;
        repeat (10) begin
            @(negedge clock_in);
            if (axil_bvalid !== 1'b1) begin
                report_failure("bvalid dropped while bready was held low");
            end
            if (axil_arready !== 1'b0) begin
                report_failure("read accepted while a write response was waiting");
            end
        end
        collect_write_response(response);
        check_response("bresp", response, OKAY);
        axil_read(CURSOR_REGISTER, data, response);
        check_response("rresp", response, OKAY);
        check_data("cursor", data, axil_data_t'(model_cursor));
    endtask

    initial begin
        seed = 22;
        mismatch_count = 0;
        failure_count = 0;
        model_cursor = 0;
        model_displayed = 1'b0;
        model_pending = 1'b0;
        reset_n_in = 1'b0;
        axil_awaddr = '0;
        axil_awvalid = 1'b0;
        axil_wdata = '0;
        axil_wvalid = 1'b0;
        axil_bready = 1'b0;
        axil_araddr = '0;
        axil_arvalid = 1'b0;
        axil_rready = 1'b0;
        repeat (5) @(negedge clock_in);
        reset_n_in = 1'b1;

        register_access();
        pixel_auto_increment();
        buffer_switch();
        tear_free_swap();
        response_back_pressure();

        $display("mismatches: %0d, other failures: %0d", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
source/display_pkg.sv
source/frame_buffers.sv
source/pixel_writer_axil.sv
source/display_scanner.sv
source/display_top.sv
bench/display_tb.sv

/* include/display_cfg.svh */
`ifndef DISPLAY_CFG_SVH
`define DISPLAY_CFG_SVH

// ----------------------------------------------------------
// display geometry
// ----------------------------------------------------------

// pixels per line and lines per frame.
`define DISPLAY_WIDTH 640
`define DISPLAY_HEIGHT 400

// memory depth and cursor wrap point.
`define DISPLAY_PIXELS (`DISPLAY_WIDTH * `DISPLAY_HEIGHT)

// linear pixel index and grey level widths.
`define PIXEL_ADDRESS_BITS 18
`define PIXEL_COLOUR_BITS 4

// ----------------------------------------------------------
// register port
// ----------------------------------------------------------

`define AXIL_ADDRESS_BITS 4
`define AXIL_DATA_BITS 32

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module display_tb \
    -f filelist.f \
    --Mdir "$BUILD_DIR" \
    -o display_sim

"$BUILD_DIR/display_sim" | tee "$LOG_FILE"

if grep -qx "=== PASS ===" "$LOG_FILE"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* source/display_pkg.sv */
`include "display_cfg.svh"

package display_pkg;

    // ----------------------------------------------------------
    // pixel store types
    // ----------------------------------------------------------

    // row times the line width plus column.
    typedef logic [`PIXEL_ADDRESS_BITS-1:0] pixel_address_t;

    // grey level, 0 is black.
    typedef logic [`PIXEL_COLOUR_BITS-1:0] pixel_colour_t;

    // ----------------------------------------------------------
    // register port types
    // ----------------------------------------------------------

    typedef logic [`AXIL_ADDRESS_BITS-1:0] axil_address_t;
    typedef logic [`AXIL_DATA_BITS-1:0] axil_data_t;
    typedef logic [1:0] axil_response_t;

    // only the two codes this slave returns.
    localparam axil_response_t RESPONSE_OKAY = 2'b00;
    localparam axil_response_t RESPONSE_SLVERR = 2'b10;

    // register slave transaction states.
    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESPONSE,
        READ_RESPONSE
    } writer_state_t;

endpackage

/* source/display_scanner.sv */
`timescale 1ns/1ps
`include "display_cfg.svh"

module display_scanner
    import display_pkg::*;
(
    input  logic           clock_in,
    input  logic           reset_n_in,

    output pixel_address_t pixel_read_address,
    output logic           pixel_read_frame_complete,
    input  pixel_colour_t  pixel_read_data,

    output pixel_colour_t  display_pixel,
    output logic           display_pixel_valid,
    output logic           display_frame_start
);

    // last linear address of the frame.
    logic frame_end;

    // ----------------------------------------------------------
    // raster address
    // ----------------------------------------------------------

    assign frame_end = (pixel_read_address == pixel_address_t'(`DISPLAY_PIXELS - 1));

    // one pixel per clock, no blanking, straight back to 0 after the end.
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            pixel_read_address <= '0;
        end else if (frame_end) begin
            pixel_read_address <= '0;
        end else begin
            pixel_read_address <= pixel_read_address + 1'b1;
        end
    end

    // issued with the last address so the buffers swap before
    // address 0 of the next frame is read.
    assign pixel_read_frame_complete = frame_end;

    // ----------------------------------------------------------
    // pixel stream
    // ----------------------------------------------------------

    // markers are delayed one cycle to line up with the memory read.
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            display_pixel_valid <= 1'b0;
            display_frame_start <= 1'b0;
        end else begin
            display_pixel_valid <= 1'b1;
            display_frame_start <= (pixel_read_address == '0);
        end
    end

    assign display_pixel = pixel_read_data;

endmodule

/* source/display_top.sv */
`timescale 1ns/1ps

module display_top
    import display_pkg::*;
(
    input  logic           clock_in,
    input  logic           reset_n_in,

    input  axil_address_t  axil_awaddr,
    input  logic           axil_awvalid,
    output logic           axil_awready,

    input  axil_data_t     axil_wdata,
    input  logic           axil_wvalid,
    output logic           axil_wready,

    output axil_response_t axil_bresp,
    output logic           axil_bvalid,
    input  logic           axil_bready,

    input  axil_address_t  axil_araddr,
    input  logic           axil_arvalid,
    output logic           axil_arready,

    output axil_data_t     axil_rdata,
    output axil_response_t axil_rresp,
    output logic           axil_rvalid,
    input  logic           axil_rready,

    output pixel_colour_t  display_pixel,
    output logic           display_pixel_valid,
    output logic           display_frame_start
);

    // ----------------------------------------------------------
    // writer to buffers
    // ----------------------------------------------------------

    pixel_address_t pixel_write_address;
    pixel_colour_t pixel_write_data;
    logic pixel_write_enable;
    logic switch_write_buffer;
    logic pixel_write_buffer_ready;
    logic displayed_buffer;

    // ----------------------------------------------------------
    // scanner to buffers
    // ----------------------------------------------------------

    pixel_address_t pixel_read_address;
    pixel_colour_t pixel_read_data;
    logic pixel_read_frame_complete;

    pixel_writer_axil writer0 (
        .clock_in                 (clock_in),
        .reset_n_in               (reset_n_in),
        .axil_awaddr              (axil_awaddr),
        .axil_awvalid             (axil_awvalid),
        .axil_awready             (axil_awready),
        .axil_wdata               (axil_wdata),
        .axil_wvalid              (axil_wvalid),
        .axil_wready              (axil_wready),
        .axil_bresp               (axil_bresp),
        .axil_bvalid              (axil_bvalid),
        .axil_bready              (axil_bready),
        .axil_araddr              (axil_araddr),
        .axil_arvalid             (axil_arvalid),
        .axil_arready             (axil_arready),
        .axil_rdata               (axil_rdata),
        .axil_rresp               (axil_rresp),
        .axil_rvalid              (axil_rvalid),
        .axil_rready              (axil_rready),
        .pixel_write_address      (pixel_write_address),
        .pixel_write_data         (pixel_write_data),
        .pixel_write_enable       (pixel_write_enable),
        .switch_write_buffer      (switch_write_buffer),
        .pixel_write_buffer_ready (pixel_write_buffer_ready),
        .displayed_buffer         (displayed_buffer)
    );

    frame_buffers buffers0 (
        .clock_in                  (clock_in),
        .reset_n_in                (reset_n_in),
        .pixel_write_address       (pixel_write_address),
        .pixel_write_data          (pixel_write_data),
        .pixel_write_enable        (pixel_write_enable),
        .pixel_write_buffer_ready  (pixel_write_buffer_ready),
        .pixel_read_address        (pixel_read_address),
        .pixel_read_data           (pixel_read_data),
        .pixel_read_frame_complete (pixel_read_frame_complete),
        .switch_write_buffer       (switch_write_buffer),
        .displayed_buffer          (displayed_buffer)
    );

    display_scanner scanner0 (
        .clock_in                  (clock_in),
        .reset_n_in                (reset_n_in),
        .pixel_read_address        (pixel_read_address),
        .pixel_read_frame_complete (pixel_read_frame_complete),
        .pixel_read_data           (pixel_read_data),
        .display_pixel             (display_pixel),
        .display_pixel_valid       (display_pixel_valid),
        .display_frame_start       (display_frame_start)
    );

endmodule

/* source/frame_buffers.sv */
`timescale 1ns/1ps
`include "display_cfg.svh"

module frame_buffers
    import display_pkg::*;
(
    input  logic           clock_in,
    input  logic           reset_n_in,

    input  pixel_address_t pixel_write_address,
    input  pixel_colour_t  pixel_write_data,
    input  logic           pixel_write_enable,
    output logic           pixel_write_buffer_ready,

    input  pixel_address_t pixel_read_address,
    output pixel_colour_t  pixel_read_data,
    input  logic           pixel_read_frame_complete,

    input  logic           switch_write_buffer,
    output logic           displayed_buffer
);

    // the two frame memories, one shown and one hidden.
    pixel_colour_t buffer_0 [`DISPLAY_PIXELS];
    pixel_colour_t buffer_1 [`DISPLAY_PIXELS];

    pixel_colour_t read_data_0;
    pixel_colour_t read_data_1;

    // buffer that was displayed when the current read address was issued.
    logic read_select;

    // a switch has been asked for but the frame has not ended yet.
    logic switch_pending;

    // ----------------------------------------------------------
    // write port
    // ----------------------------------------------------------

    // writes only ever land in the hidden buffer.
    always_ff @(posedge clock_in) begin
        if (pixel_write_enable && displayed_buffer) begin
            buffer_0[pixel_write_address] <= pixel_write_data;
        end
    end

    always_ff @(posedge clock_in) begin
        if (pixel_write_enable && !displayed_buffer) begin
            buffer_1[pixel_write_address] <= pixel_write_data;
        end
    end

    // ----------------------------------------------------------
    // read port
    // ----------------------------------------------------------

    // both memories are read every cycle and the output is picked
    // afterwards, so each array stays a plain single-port RAM.
    always_ff @(posedge clock_in) begin
        read_data_0 <= buffer_0[pixel_read_address];
        read_data_1 <= buffer_1[pixel_read_address];
        read_select <= displayed_buffer;
    end

    assign pixel_read_data = read_select ? read_data_1 : read_data_0;

    // ----------------------------------------------------------
    // buffer swap
    // ----------------------------------------------------------

    // the swap only happens at the frame boundary, so the scanner
    // never shows half of one buffer and half of the other.
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            switch_pending <= 1'b0;
            displayed_buffer <= 1'b0;
        end else begin
            if (pixel_read_frame_complete && switch_pending) begin
                displayed_buffer <= !displayed_buffer;
                switch_pending <= 1'b0;
            end else if (switch_write_buffer) begin
                switch_pending <= 1'b1;
            end
        end
    end

    // hidden buffer is busy while a swap waits for the frame end.
    assign pixel_write_buffer_ready = !switch_pending;

endmodule

/* source/pixel_writer_axil.sv */
`timescale 1ns/1ps
`include "display_cfg.svh"

module pixel_writer_axil
    import display_pkg::*;
(
    input  logic           clock_in,
    input  logic           reset_n_in,

    input  axil_address_t  axil_awaddr,
    input  logic           axil_awvalid,
    output logic           axil_awready,

    input  axil_data_t     axil_wdata,
    input  logic           axil_wvalid,
    output logic           axil_wready,

    output axil_response_t axil_bresp,
    output logic           axil_bvalid,
    input  logic           axil_bready,

    input  axil_address_t  axil_araddr,
    input  logic           axil_arvalid,
    output logic           axil_arready,

    output axil_data_t     axil_rdata,
    output axil_response_t axil_rresp,
    output logic           axil_rvalid,
    input  logic           axil_rready,

    output pixel_address_t pixel_write_address,
    output pixel_colour_t  pixel_write_data,
    output logic           pixel_write_enable,
    output logic           switch_write_buffer,
    input  logic           pixel_write_buffer_ready,
    input  logic           displayed_buffer
);

    // register map.
    localparam axil_address_t CURSOR_OFFSET = 4'h0;
    localparam axil_address_t PIXEL_OFFSET = 4'h4;
    localparam axil_address_t CONTROL_OFFSET = 4'h8;

    writer_state_t state;

    pixel_address_t cursor;
    pixel_address_t cursor_next;
    pixel_address_t cursor_written;

    logic write_present;
    logic write_accept;
    logic read_accept;

    axil_response_t write_response;
    axil_response_t read_response;
    axil_data_t read_value;

    // ----------------------------------------------------------
    // handshakes
    // ----------------------------------------------------------

    // address and data are taken in the same cycle, and a pending
    // write keeps any read waiting.
    assign write_present = axil_awvalid | axil_wvalid;
    assign write_accept = (state == IDLE) && axil_awvalid && axil_wvalid;
    assign read_accept = (state == IDLE) && axil_arvalid && !write_present;

    assign axil_awready = write_accept;
    assign axil_wready = write_accept;
    assign axil_arready = read_accept;

    assign axil_bvalid = (state == WRITE_RESPONSE);
    assign axil_rvalid = (state == READ_RESPONSE);

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (write_accept) begin
                        state <= WRITE_RESPONSE;
                    end else if (read_accept) begin
                        state <= READ_RESPONSE;
                    end
                end
                WRITE_RESPONSE: begin
                    if (axil_bready) begin
                        state <= IDLE;
                    end
                end
                READ_RESPONSE: begin
                    if (axil_rready) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // cursor
    // ----------------------------------------------------------

    // wraps back to the first pixel after the last one.
    assign cursor_next = (cursor == pixel_address_t'(`DISPLAY_PIXELS - 1)) ?
                         '0 : cursor + 1'b1;

    // values past the end of the frame land on pixel 0.
    assign cursor_written = (axil_wdata >= axil_data_t'(`DISPLAY_PIXELS)) ?
                            '0 : axil_wdata[`PIXEL_ADDRESS_BITS-1:0];

    // ----------------------------------------------------------
    // register decode
    // ----------------------------------------------------------

    always_comb begin
        write_response = RESPONSE_OKAY;
        if (axil_awaddr == PIXEL_OFFSET) begin
            // hidden buffer is locked while a swap is pending.
            if (!pixel_write_buffer_ready) begin
                write_response = RESPONSE_SLVERR;
            end
        end else if (axil_awaddr != CURSOR_OFFSET && axil_awaddr != CONTROL_OFFSET) begin
            write_response = RESPONSE_SLVERR;
        end
    end

    always_comb begin
        read_value = '0;
        read_response = RESPONSE_OKAY;
        case (axil_araddr)
            CURSOR_OFFSET: begin
                read_value = axil_data_t'(cursor);
            end
            PIXEL_OFFSET: begin
                // write only, reads back as zero.
                read_value = '0;
            end
            CONTROL_OFFSET: begin
                read_value = {{(`AXIL_DATA_BITS - 2){1'b0}}, displayed_buffer,
                              pixel_write_buffer_ready};
            end
            default: begin
                read_response = RESPONSE_SLVERR;
            end
        endcase
    end

    // ----------------------------------------------------------
    // register updates
    // ----------------------------------------------------------

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            cursor <= '0;
            pixel_write_enable <= 1'b0;
            switch_write_buffer <= 1'b0;
        end else begin
            pixel_write_enable <= 1'b0;
            switch_write_buffer <= 1'b0;
            if (write_accept) begin
                if (axil_awaddr == CURSOR_OFFSET) begin
                    cursor <= cursor_written;
                end else if (axil_awaddr == PIXEL_OFFSET && pixel_write_buffer_ready) begin
                    pixel_write_enable <= 1'b1;
                    cursor <= cursor_next;
                end else if (axil_awaddr == CONTROL_OFFSET) begin
                    switch_write_buffer <= axil_wdata[0];
                end
            end
        end
    end

    // write payload and responses, captured at the handshake.
    always_ff @(posedge clock_in) begin
        if (write_accept) begin
            pixel_write_address <= cursor;
            pixel_write_data <= axil_wdata[`PIXEL_COLOUR_BITS-1:0];
            axil_bresp <= write_response;
        end
        if (read_accept) begin
            axil_rdata <= read_value;
            axil_rresp <= read_response;
        end
    end

endmodule
